/* logic/gpio_apb_regs.sv */
// APB register file for the GPIO block
// Write decode, configuration registers, output set/clear
// and the read multiplexer

`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_apb_regs
(
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic [`GPIO_ADDR_W-1:0]   PADDR,
    input  logic [`GPIO_DATA_W-1:0]   PWDATA,
    input  logic                      PWRITE,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    output logic [`GPIO_DATA_W-1:0]   PRDATA,
    input  logic [`GPIO_PAD_NUM-1:0]  pad_in,
    input  logic [`GPIO_PAD_NUM-1:0]  int_status,
    output logic [`GPIO_PAD_NUM-1:0]  pad_dir,
    output logic [`GPIO_PAD_NUM-1:0]  pad_out,
    output logic [`GPIO_PAD_NUM-1:0]  pad_en,
    output logic [`GPIO_PAD_NUM-1:0]  int_en,
    output gpio_pkg::apb_word_u       inttype_lo,
    output gpio_pkg::apb_word_u       inttype_hi,
    output logic                      status_rd
);

    logic [`GPIO_IDX_MSB-`GPIO_IDX_LSB:0] reg_idx;
    logic                                 wr_access;
    logic                                 rd_access;

    assign reg_idx   = PADDR[`GPIO_IDX_MSB:`GPIO_IDX_LSB];
    assign wr_access = PSEL & PENABLE & PWRITE;
    assign rd_access = PSEL & PENABLE & ~PWRITE;

    // Status clear request, one access cycle long
    assign status_rd = rd_access && (reg_idx == `GPIO_REG_INTSTATUS);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            pad_dir         <= '0;
            pad_out         <= '0;
            pad_en          <= '0;
            int_en          <= '0;
            inttype_lo.bits <= '0;  // Type 00 on all pads
            inttype_hi.bits <= '0;
        end
        else if (wr_access)
        begin
            case (reg_idx)
                `GPIO_REG_PADDIR:
                    pad_dir <= PWDATA;
                `GPIO_REG_GPIOEN:
                    pad_en <= PWDATA;
                `GPIO_REG_PADOUT:
                    pad_out <= PWDATA;
                `GPIO_REG_PADOUTSET:
                    pad_out <= pad_out | PWDATA;
                `GPIO_REG_PADOUTCLR:
                    pad_out <= pad_out & ~PWDATA;  // Ones in data clear
                `GPIO_REG_INTEN:
                    int_en <= PWDATA;
                `GPIO_REG_INTTYPE_00_15:
                    inttype_lo.bits <= PWDATA;
                `GPIO_REG_INTTYPE_16_31:
                    inttype_hi.bits <= PWDATA;
                default:
                begin
                    // Read-only or unmapped, write ignored
                end
            endcase
        end
    end

    // Bus is idle-zero outside read access cycles
    always_comb
    begin
        PRDATA = '0;
        if (rd_access)
        begin
            case (reg_idx)
                `GPIO_REG_PADDIR:
                    PRDATA = pad_dir;
                `GPIO_REG_GPIOEN:
                    PRDATA = pad_en;
                `GPIO_REG_PADIN:
                    PRDATA = pad_in;
                `GPIO_REG_PADOUT:
                    PRDATA = pad_out;
                `GPIO_REG_INTEN:
                    PRDATA = int_en;
                `GPIO_REG_INTTYPE_00_15:
                    PRDATA = inttype_lo.bits;
                `GPIO_REG_INTTYPE_16_31:
                    PRDATA = inttype_hi.bits;
                `GPIO_REG_INTSTATUS:
                    PRDATA = int_status;  // Cleared after this cycle
                default:
                    PRDATA = '0;  // Unmapped and write-only words
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/gpio_input_sync.sv */
// Pad input synchronizer
// Two sync stages plus a history stage, rise and fall pulses

`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_input_sync
(
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic [`GPIO_PAD_NUM-1:0]  gpio_in,
    output logic [`GPIO_PAD_NUM-1:0]  pad_sync,
    output logic [`GPIO_PAD_NUM-1:0]  pad_in,
    output logic [`GPIO_PAD_NUM-1:0]  pad_rise,
    output logic [`GPIO_PAD_NUM-1:0]  pad_fall
);

    logic [`GPIO_PAD_NUM-1:0] sync_meta;  // First stage, may go metastable

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync_meta <= '0;
            pad_sync  <= '0;
            pad_in    <= '0;
        end
        else
        begin
            sync_meta <= gpio_in;
            pad_sync  <= sync_meta;
            pad_in    <= pad_sync;  // Previous synchronized value
        end
    end

    assign pad_rise = pad_sync & ~pad_in;
    assign pad_fall = ~pad_sync & pad_in;

endmodule

`default_nettype wire

/* logic/gpio_irq_ctrl.sv */
// GPIO interrupt controller
// Per-pad type match, sticky status with read clear, interrupt line

`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_irq_ctrl
(
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic [`GPIO_PAD_NUM-1:0]  pad_rise,
    input  logic [`GPIO_PAD_NUM-1:0]  pad_fall,
    input  logic [`GPIO_PAD_NUM-1:0]  pad_en,
    input  logic [`GPIO_PAD_NUM-1:0]  int_en,
    input  gpio_pkg::apb_word_u       inttype_lo,
    input  gpio_pkg::apb_word_u       inttype_hi,
    input  logic                      status_rd,
    output logic [`GPIO_PAD_NUM-1:0]  int_status,
    output logic                      interrupt
);

    localparam int FIELDS = `GPIO_DATA_W / 2;  // Pads per type register

    logic [`GPIO_PAD_NUM-1:0] type_hit;
    logic [`GPIO_PAD_NUM-1:0] event_hit;

    function automatic logic edge_match(input logic [1:0] code, input logic rise,
                                        input logic fall);
        case (code)
            `GPIO_INT_FALL: edge_match = fall;
            `GPIO_INT_RISE: edge_match = rise;
            `GPIO_INT_BOTH: edge_match = rise | fall;
            default:        edge_match = 1'b0;  // Type 11 never fires
        endcase
    endfunction

    always_comb
    begin
        for (int i = 0; i < FIELDS; i++)
        begin
            type_hit[i]          = edge_match(inttype_lo.inttype[i], pad_rise[i],
                                              pad_fall[i]);
            type_hit[i + FIELDS] = edge_match(inttype_hi.inttype[i], pad_rise[i + FIELDS],
                                              pad_fall[i + FIELDS]);
        end
    end

    assign event_hit = type_hit & pad_en & int_en;
    assign interrupt = |event_hit;  // Same-cycle pulse

    // New events win over a read clear in the same cycle
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            int_status <= '0;
        else if (interrupt)
            int_status <= int_status | event_hit;
        else if (status_rd)
            int_status <= '0;
    end

endmodule

`default_nettype wire

/* logic/gpio_params.svh */
// Shared constants for the APB GPIO block
// Pad count, bus widths, register word indices and interrupt type codes

`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

`define GPIO_PAD_NUM            32
`define GPIO_DATA_W             32
`define GPIO_ADDR_W             12

// Word index taken from the byte address
`define GPIO_IDX_MSB            6
`define GPIO_IDX_LSB            2

`define GPIO_REG_PADDIR         5'd0   // 0x00
`define GPIO_REG_GPIOEN         5'd2   // 0x08
`define GPIO_REG_PADIN          5'd4   // 0x10
`define GPIO_REG_PADOUT         5'd6   // 0x18
`define GPIO_REG_PADOUTSET      5'd8   // 0x20
`define GPIO_REG_PADOUTCLR      5'd10  // 0x28
`define GPIO_REG_INTEN          5'd12  // 0x30
`define GPIO_REG_INTTYPE_00_15  5'd14  // 0x38
`define GPIO_REG_INTTYPE_16_31  5'd15  // 0x3C
`define GPIO_REG_INTSTATUS      5'd18  // 0x48

// Code 2'b11 disables the pad interrupt
`define GPIO_INT_FALL           2'b00
`define GPIO_INT_RISE           2'b01
`define GPIO_INT_BOTH           2'b10

`endif

/* logic/gpio_pkg.sv */
// Types for the APB GPIO block
// APB data word seen flat or as sixteen 2-bit interrupt type fields

`default_nettype none

`include "gpio_params.svh"

package gpio_pkg;

    typedef logic [`GPIO_DATA_W-1:0] apb_word_t;

    typedef logic [`GPIO_DATA_W/2-1:0][1:0] inttype_fields_t;

    // One register word, decoded both ways
    typedef union packed
    {
        apb_word_t       bits;     // Flat APB view
        inttype_fields_t inttype;  // Per-pad type codes
    } apb_word_u;

endpackage

`default_nettype wire

/* logic/gpio_top.sv */
// APB GPIO block, 32 pads
// Register file, input synchronizer and interrupt controller

`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_top
(
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic [`GPIO_ADDR_W-1:0]   PADDR,
    input  logic [`GPIO_DATA_W-1:0]   PWDATA,
    input  logic                      PWRITE,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    output logic [`GPIO_DATA_W-1:0]   PRDATA,
    output logic                      PREADY,
    output logic                      PSLVERR,
    input  logic [`GPIO_PAD_NUM-1:0]  gpio_in,
    output logic [`GPIO_PAD_NUM-1:0]  gpio_in_sync,
    output logic [`GPIO_PAD_NUM-1:0]  gpio_out,
    output logic [`GPIO_PAD_NUM-1:0]  gpio_dir,
    output logic                      interrupt
);

    import gpio_pkg::*;

    logic [`GPIO_PAD_NUM-1:0] pad_en;
    logic [`GPIO_PAD_NUM-1:0] int_en;
    logic [`GPIO_PAD_NUM-1:0] int_status;
    logic [`GPIO_PAD_NUM-1:0] pad_in;
    logic [`GPIO_PAD_NUM-1:0] pad_rise;
    logic [`GPIO_PAD_NUM-1:0] pad_fall;
    apb_word_u                inttype_lo;
    apb_word_u                inttype_hi;
    logic                     status_rd;

    assign PREADY  = 1'b1;  // No wait states
    assign PSLVERR = 1'b0;

    gpio_apb_regs u_regs
    (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .PADDR      (PADDR),
        .PWDATA     (PWDATA),
        .PWRITE     (PWRITE),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PRDATA     (PRDATA),
        .pad_in     (pad_in),
        .int_status (int_status),
        .pad_dir    (gpio_dir),
        .pad_out    (gpio_out),
        .pad_en     (pad_en),
        .int_en     (int_en),
        .inttype_lo (inttype_lo),
        .inttype_hi (inttype_hi),
        .status_rd  (status_rd)
    );

    gpio_input_sync u_sync
    (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .gpio_in  (gpio_in),
        .pad_sync (gpio_in_sync),
        .pad_in   (pad_in),
        .pad_rise (pad_rise),
        .pad_fall (pad_fall)
    );

    gpio_irq_ctrl u_irq
    (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .pad_rise   (pad_rise),
        .pad_fall   (pad_fall),
        .pad_en     (pad_en),
        .int_en     (int_en),
        .inttype_lo (inttype_lo),
        .inttype_hi (inttype_hi),
        .status_rd  (status_rd),
        .int_status (int_status),
        .interrupt  (interrupt)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the GPIO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_gpio -f sim.f -o tb_gpio

./obj_dir/tb_gpio > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* sim.f */
+incdir+logic
logic/gpio_pkg.sv
logic/gpio_input_sync.sv
logic/gpio_irq_ctrl.sv
logic/gpio_apb_regs.sv
logic/gpio_top.sv
tb/tb_gpio.sv

/* tb/tb_gpio.sv */
// Testbench for the APB GPIO block
// APB read/write tasks, xorshift masks, output and interrupt models

`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module tb_gpio;

    localparam int MAX_CYCLES = 3000;  // Well beyond the test length

    logic        HCLK;
    logic        HRESETn;
    logic [11:0] PADDR;
    logic [31:0] PWDATA;
    logic        PWRITE;
    logic        PSEL;
    logic        PENABLE;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;
    logic [31:0] gpio_in;
    logic [31:0] gpio_in_sync;
    logic [31:0] gpio_out;
    logic [31:0] gpio_dir;
    logic        interrupt;
    logic [31:0] rng_state = 32'd48192;
    int          err_count = 0;
    int          errs_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;

    gpio_top uut (.*);

    initial
    begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;
    end

    always @(posedge HCLK)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Bus never stalls or errors
    assert property (@(posedge HCLK) PREADY && !PSLVERR)
    else
    begin
        $display("ERR %0t: PREADY or PSLVERR not at fixed value", $time);
        err_count++;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Event mask from type codes, 00 fall, 01 rise, 10 both, 11 none
    function automatic logic [31:0] expected_events(input logic [31:0] tlo,
        input logic [31:0] thi, input logic [31:0] rise, input logic [31:0] fall);
        logic [63:0] types;
        logic [31:0] ev;
        types = {thi, tlo};
        for (int p = 0; p < 32; p++)
        begin
            case (types[2*p +: 2])
                `GPIO_INT_FALL: ev[p] = fall[p];
                `GPIO_INT_RISE: ev[p] = rise[p];
                `GPIO_INT_BOTH: ev[p] = rise[p] | fall[p];
                default:        ev[p] = 1'b0;
            endcase
        end
        return ev;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp)
        else
        begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic apb_write(input logic [4:0] idx, input logic [31:0] data);
        PADDR  = {5'b0, idx, 2'b00};
        PWDATA = data;
        PWRITE = 1'b1;
        PSEL   = 1'b1;
        @(posedge HCLK); #1;
        PENABLE = 1'b1;
        @(posedge HCLK); #1;  // Write lands at this edge
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] idx, output logic [31:0] data);
        PADDR  = {5'b0, idx, 2'b00};
        PWRITE = 1'b0;
        PSEL   = 1'b1;
        @(posedge HCLK); #1;
        PENABLE = 1'b1;
        #4 data = PRDATA;  // Mid access cycle
        @(posedge HCLK); #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    // Pulse expected between the second and third edge after the change
    task automatic drive_pads(input logic [31:0] value, input logic [31:0] exp_ev);
        gpio_in = value;
        @(posedge HCLK); #1;
        check_value({31'b0, interrupt}, 32'd0, "interrupt before pulse");
        @(posedge HCLK); #1;
        check_value({31'b0, interrupt}, {31'b0, |exp_ev}, "interrupt pulse");
        @(posedge HCLK); #1;
        check_value({31'b0, interrupt}, 32'd0, "interrupt after pulse");
    endtask

    task automatic finish_test(input string name);
        if (err_count == errs_at_start)
            tests_passed++;
        else
            tests_failed++;
        $display("Test %s: %s", name, (err_count == errs_at_start) ? "pass" : "fail");
        errs_at_start = err_count;
    endtask

    initial
    begin
        logic [31:0] rd;
        logic [31:0] w;
        logic [31:0] dir_word;
        logic [31:0] out_model;
        logic [31:0] cur_in;
        logic [31:0] tlo;
        logic [31:0] thi;
        logic [31:0] ev1;
        logic [31:0] ev2;
        HRESETn = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        PWRITE  = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        gpio_in = '0;
        cur_in  = '0;
        repeat (8) @(posedge HCLK);
        #1 HRESETn = 1'b1;

        check_value(gpio_out | gpio_dir, 32'd0, "gpio_out/gpio_dir after reset");
        check_value({31'b0, interrupt}, 32'd0, "interrupt after reset");
        for (int i = 0; i < 32; i++)
        begin
            apb_read(i[4:0], rd);
            check_value(rd, 32'd0, $sformatf("index %0d after reset", i));
        end
        finish_test("reset_state");

        dir_word = '0;
        for (int r = 0; r < 15; r++)
        begin
            logic [4:0] idx;
            idx = (r % 5 == 0) ? `GPIO_REG_PADDIR : (r % 5 == 1) ? `GPIO_REG_GPIOEN :
                  (r % 5 == 2) ? `GPIO_REG_INTEN : (r % 5 == 3) ?
                  `GPIO_REG_INTTYPE_00_15 : `GPIO_REG_INTTYPE_16_31;
            w = next_random();
            apb_write(idx, w);
            if (idx == `GPIO_REG_PADDIR)
                dir_word = w;
            check_value(gpio_dir, dir_word, "gpio_dir after write");
            apb_read(idx, rd);
            check_value(rd, w, $sformatf("readback index %0d", idx));
        end
        finish_test("readback");

        out_model = next_random();
        apb_write(`GPIO_REG_PADOUT, out_model);
        for (int r = 0; r < 9; r++)
        begin
            if (r > 0)
            begin
                w = next_random();
                apb_write((r % 2) ? `GPIO_REG_PADOUTSET : `GPIO_REG_PADOUTCLR, w);
                out_model = (r % 2) ? (out_model | w) : (out_model & ~w);
            end
            check_value(gpio_out, out_model, "gpio_out");
            apb_read(`GPIO_REG_PADOUT, rd);
            check_value(rd, out_model, "PADOUT readback");
        end
        finish_test("output_set_clear");

        for (int k = 0; k < 3; k++)
        begin
            w = next_random();
            gpio_in = w;
            @(posedge HCLK); #1;
            check_value(gpio_in_sync, cur_in, "gpio_in_sync one cycle later");
            @(posedge HCLK); #1;
            check_value(gpio_in_sync, w, "gpio_in_sync two cycles later");
            apb_read(`GPIO_REG_PADIN, rd);
            check_value(rd, w, "PADIN readback");
            cur_in = w;
        end
        finish_test("input_sync");

        apb_write(`GPIO_REG_GPIOEN, 32'hFFFF_FFFF);
        apb_write(`GPIO_REG_INTEN, 32'hFFFF_FFFF);
        for (int r = 0; r < 2; r++)
        begin
            tlo = next_random();
            thi = next_random();
            apb_write(`GPIO_REG_INTTYPE_00_15, tlo);
            apb_write(`GPIO_REG_INTTYPE_16_31, thi);
            apb_read(`GPIO_REG_INTSTATUS, rd);  // Drop leftover status
            w = next_random();
            ev1 = expected_events(tlo, thi, w & ~cur_in, ~w & cur_in);
            drive_pads(w, ev1);
            ev2 = expected_events(tlo, thi, ~w, w);
            drive_pads(~w, ev2);
            cur_in = ~w;
            apb_read(`GPIO_REG_INTSTATUS, rd);
            check_value(rd, ev1 | ev2, "INTSTATUS after both changes");
            apb_read(`GPIO_REG_INTSTATUS, rd);
            check_value(rd, 32'd0, "INTSTATUS after clear");
        end
        finish_test("interrupt_types");

        // Pad 3 disabled, pad 9 masked, pad 20 type 11, pad 27 live
        apb_write(`GPIO_REG_GPIOEN, ~32'h0000_0008);
        apb_write(`GPIO_REG_INTEN, ~32'h0000_0200);
        apb_write(`GPIO_REG_INTTYPE_00_15, 32'hFFFB_FFBF);  // Pads 3 and 9 both edges
        apb_write(`GPIO_REG_INTTYPE_16_31, 32'hFFBF_FFFF);  // Pad 27 both edges
        apb_read(`GPIO_REG_INTSTATUS, rd);
        cur_in = cur_in ^ 32'h0010_0208;
        drive_pads(cur_in, 32'd0);
        apb_read(`GPIO_REG_INTSTATUS, rd);
        check_value(rd, 32'd0, "INTSTATUS with gated pads only");
        cur_in = cur_in ^ 32'h0810_0208;
        drive_pads(cur_in, 32'h0800_0000);
        apb_read(`GPIO_REG_INTSTATUS, rd);
        check_value(rd, 32'h0800_0000, "INTSTATUS with pad 27 enabled");
        apb_read(`GPIO_REG_INTSTATUS, rd);
        check_value(rd, 32'd0, "INTSTATUS after clear");
        finish_test("interrupt_gating");

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed,
                 tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
